//--- src/rv_pkg.sv
package rv_pkg;

	// RV32I base opcodes, instruction bits [6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	// ECALL and the dropped CSR group
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// ALU operand A source
	typedef enum logic [1:0] {
		ALU_A_NONE,
		ALU_A_PC,
		ALU_A_RD1
	} alu_a_sel_e;

	// ALU operand B source
	typedef enum logic [1:0] {
		ALU_B_NONE,
		ALU_B_IMM,
		ALU_B_RD2,
		ALU_B_SHAMT
	} alu_b_sel_e;

	// Register file write data source
	typedef enum logic [2:0] {
		RF_WD_NONE,
		RF_WD_LUI,
		RF_WD_ALU,
		// Link value, PC + 4
		RF_WD_JUMP,
		RF_WD_LOAD
	} rf_wd_sel_e;

	// ALU operations; compares give 1 or 0
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_EQ,
		ALU_NE,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	// Decoded control bundle, 17 bits
	typedef struct packed {
		logic       jump;
		logic       branch;
		alu_a_sel_e alu_a_sel;
		alu_b_sel_e alu_b_sel;
		alu_op_e    alu_op;
		logic       rf_write;
		rf_wd_sel_e rf_wd_sel;
		logic       mem_read;
		logic       mem_write;
		logic       halt;
	} ctrl_t;

	// Word-addressed memory request
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
	} mem_req_t;

	// Read data; a write also gets one as its ack
	typedef struct packed {
		logic [31:0] rdata;
	} mem_rsp_t;

endpackage

//--- src/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input  logic [6:0]    opcode,
	input  logic [2:0]    funct3,
	input  logic          funct7_b5,
	output rv_pkg::ctrl_t ctrl
);

	// Arithmetic op from funct3 with alt picking SUB or SRA
	function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  op = rv_pkg::ALU_SLL;
			3'b010:  op = rv_pkg::ALU_SLT;
			3'b011:  op = rv_pkg::ALU_SLTU;
			3'b100:  op = rv_pkg::ALU_XOR;
			3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  op = rv_pkg::ALU_OR;
			default: op = rv_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	// Branch compare from funct3
	function automatic rv_pkg::alu_op_e branch_op(input logic [2:0] f3);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = rv_pkg::ALU_EQ;
			3'b001:  op = rv_pkg::ALU_NE;
			3'b100:  op = rv_pkg::ALU_SLT;
			3'b101:  op = rv_pkg::ALU_GE;
			3'b110:  op = rv_pkg::ALU_SLTU;
			3'b111:  op = rv_pkg::ALU_GEU;
			// Reserved encodings leave the branch flag low
			default: op = rv_pkg::ALU_NE;
		endcase
		return op;
	endfunction

	always_comb begin
		// No-op defaults for FENCE and unknown opcodes
		ctrl.jump      = 1'b0;
		ctrl.branch    = 1'b0;
		ctrl.alu_a_sel = rv_pkg::ALU_A_NONE;
		ctrl.alu_b_sel = rv_pkg::ALU_B_NONE;
		ctrl.alu_op    = rv_pkg::ALU_ADD;
		ctrl.rf_write  = 1'b0;
		ctrl.rf_wd_sel = rv_pkg::RF_WD_NONE;
		ctrl.mem_read  = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.halt      = 1'b0;

		case (opcode)
			rv_pkg::OP_LUI: begin
				// Upper immediate straight to rd
				ctrl.rf_write  = 1'b1;
				ctrl.rf_wd_sel = rv_pkg::RF_WD_LUI;
			end
			rv_pkg::OP_AUIPC: begin
				// PC + upper immediate
				ctrl.alu_a_sel = rv_pkg::ALU_A_PC;
				ctrl.alu_b_sel = rv_pkg::ALU_B_IMM;
				ctrl.rf_write  = 1'b1;
				ctrl.rf_wd_sel = rv_pkg::RF_WD_ALU;
			end
			rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
				// Target from ALU and link PC + 4
				ctrl.jump      = 1'b1;
				ctrl.alu_a_sel = (opcode == rv_pkg::OP_JAL) ? rv_pkg::ALU_A_PC
				                                            : rv_pkg::ALU_A_RD1;
				ctrl.alu_b_sel = rv_pkg::ALU_B_IMM;
				ctrl.rf_write  = 1'b1;
				ctrl.rf_wd_sel = rv_pkg::RF_WD_JUMP;
			end
			rv_pkg::OP_BRANCH: begin
				// Compare rs1 with rs2 for the six defined encodings
				ctrl.branch    = (funct3[2:1] != 2'b01);
				ctrl.alu_a_sel = rv_pkg::ALU_A_RD1;
				ctrl.alu_b_sel = rv_pkg::ALU_B_RD2;
				ctrl.alu_op    = branch_op(funct3);
			end
			rv_pkg::OP_LOAD, rv_pkg::OP_STORE: begin
				// Address is rs1 + imm
				ctrl.alu_a_sel = rv_pkg::ALU_A_RD1;
				ctrl.alu_b_sel = rv_pkg::ALU_B_IMM;
				ctrl.mem_read  = (opcode == rv_pkg::OP_LOAD);
				ctrl.mem_write = (opcode == rv_pkg::OP_STORE);
				ctrl.rf_write  = (opcode == rv_pkg::OP_LOAD);
				ctrl.rf_wd_sel = (opcode == rv_pkg::OP_LOAD) ? rv_pkg::RF_WD_LOAD
				                                             : rv_pkg::RF_WD_NONE;
			end
			rv_pkg::OP_ITYPE: begin
				ctrl.alu_a_sel = rv_pkg::ALU_A_RD1;
				// Shifts take shamt and the rest the I immediate
				ctrl.alu_b_sel = (funct3 == 3'b001 || funct3 == 3'b101) ? rv_pkg::ALU_B_SHAMT
				                                                        : rv_pkg::ALU_B_IMM;
				// Bit 30 only means SRAI here
				ctrl.alu_op    = arith_op(funct3, funct7_b5 && funct3 == 3'b101);
				ctrl.rf_write  = 1'b1;
				ctrl.rf_wd_sel = rv_pkg::RF_WD_ALU;
			end
			rv_pkg::OP_RTYPE: begin
				ctrl.alu_a_sel = rv_pkg::ALU_A_RD1;
				ctrl.alu_b_sel = rv_pkg::ALU_B_RD2;
				ctrl.alu_op    = arith_op(funct3, funct7_b5);
				ctrl.rf_write  = 1'b1;
				ctrl.rf_wd_sel = rv_pkg::RF_WD_ALU;
			end
			rv_pkg::OP_SYSTEM: begin
				// ECALL halts while CSR encodings stay no-ops
				ctrl.halt = (funct3 == 3'b000);
			end
			default: begin
			end
		endcase
	end

endmodule

//--- src/alu.sv
`timescale 1ns/10ps

module alu (
	input  rv_pkg::alu_op_e op,
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	output logic [31:0]     result
);

	logic [4:0] shamt;

	// Shift amount from low five bits only
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD:  result = a + b;
			rv_pkg::ALU_SUB:  result = a - b;
			rv_pkg::ALU_SLL:  result = a << shamt;
			rv_pkg::ALU_SRL:  result = a >> shamt;
			// Arithmetic shift keeps the sign
			rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
			rv_pkg::ALU_XOR:  result = a ^ b;
			rv_pkg::ALU_OR:   result = a | b;
			rv_pkg::ALU_AND:  result = a & b;
			// Compares land in bit zero
			rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			rv_pkg::ALU_SLTU: result = {31'b0, a < b};
			rv_pkg::ALU_EQ:   result = {31'b0, a == b};
			rv_pkg::ALU_NE:   result = {31'b0, a != b};
			rv_pkg::ALU_GE:   result = {31'b0, $signed(a) >= $signed(b)};
			rv_pkg::ALU_GEU:  result = {31'b0, a >= b};
			default:          result = 32'b0;
		endcase
	end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic        we,
	input  logic [4:0]  rd,
	input  logic [31:0] wd
);

	logic [31:0] regs [32];

	// Asynchronous reads
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (we && rd != 5'd0) begin
			// x0 never written, stays zero from reset
			regs[rd] <= wd;
		end
	end

endmodule

//--- src/core_datapath.sv
`timescale 1ns/10ps

module core_datapath #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	output logic             halted,
	output logic             req_valid,
	output rv_pkg::mem_req_t req,
	input  logic             rsp_valid,
	input  rv_pkg::mem_rsp_t rsp
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_FETCH_WAIT,
		S_EXEC,
		S_DATA_WAIT,
		S_HALT
	} state_e;

	state_e        state;
	logic [31:0]   pc;
	logic [31:0]   ir;
	logic          credit;
	rv_pkg::ctrl_t ctrl;
	logic [31:0]   rd1;
	logic [31:0]   rd2;
	logic [31:0]   imm;
	logic [31:0]   alu_a;
	logic [31:0]   alu_b;
	logic [31:0]   alu_result;
	logic [31:0]   pc_plus4;
	logic [31:0]   pc_branch;
	logic [31:0]   pc_next;
	logic          rf_we;
	logic [31:0]   rf_wd;
	logic          data_req;

	control_unit control_unit_inst (
		.opcode    (ir[6:0]),
		.funct3    (ir[14:12]),
		.funct7_b5 (ir[30]),
		.ctrl      (ctrl)
	);

	reg_file reg_file_inst (
		.clk (clk),
		.rst (rst),
		.rs1 (ir[19:15]),
		.rs2 (ir[24:20]),
		.rd1 (rd1),
		.rd2 (rd2),
		.we  (rf_we),
		.rd  (ir[11:7]),
		.wd  (rf_wd)
	);

	alu alu_inst (
		.op     (ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

	// Immediate by instruction format
	always_comb begin
		case (ir[6:0])
			rv_pkg::OP_STORE:  imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
			rv_pkg::OP_BRANCH: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			rv_pkg::OP_LUI,
			rv_pkg::OP_AUIPC:  imm = {ir[31:12], 12'b0};
			rv_pkg::OP_JAL:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			// I format for JALR, loads and ITYPE
			default:           imm = {{21{ir[31]}}, ir[30:20]};
		endcase
	end

	// Operand muxes
	always_comb begin
		case (ctrl.alu_a_sel)
			rv_pkg::ALU_A_PC:  alu_a = pc;
			rv_pkg::ALU_A_RD1: alu_a = rd1;
			default:           alu_a = 32'b0;
		endcase
		case (ctrl.alu_b_sel)
			rv_pkg::ALU_B_IMM:   alu_b = imm;
			rv_pkg::ALU_B_RD2:   alu_b = rd2;
			rv_pkg::ALU_B_SHAMT: alu_b = {27'b0, ir[24:20]};
			default:             alu_b = 32'b0;
		endcase
	end

	// Next PC; ALU is busy comparing, so branches get their own adder
	assign pc_plus4  = pc + 32'd4;
	assign pc_branch = pc + imm;
	always_comb begin
		if (ctrl.jump) begin
			// JALR target bit zero cleared
			pc_next = {alu_result[31:1], 1'b0};
		end else if (ctrl.branch && alu_result[0]) begin
			pc_next = pc_branch;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// Write-back select
	always_comb begin
		case (ctrl.rf_wd_sel)
			rv_pkg::RF_WD_LUI:  rf_wd = imm;
			rv_pkg::RF_WD_ALU:  rf_wd = alu_result;
			rv_pkg::RF_WD_JUMP: rf_wd = pc_plus4;
			rv_pkg::RF_WD_LOAD: rf_wd = rsp.rdata;
			default:            rf_wd = 32'b0;
		endcase
	end

	// Loads write back when their data returns
	assign rf_we = (state == S_EXEC && ctrl.rf_write && !ctrl.mem_read) ||
	               (state == S_DATA_WAIT && rsp_valid && ctrl.mem_read);

	// Fetch or data request, only while holding the credit
	assign data_req  = (state == S_EXEC);
	assign req_valid = credit &&
	                   (state == S_FETCH || (data_req && (ctrl.mem_read || ctrl.mem_write)));
	assign req.addr  = data_req ? {2'b00, alu_result[31:2]} : {2'b00, pc[31:2]};
	assign req.wdata = rd2;
	assign req.we    = data_req && ctrl.mem_write;

	assign halted = (state == S_HALT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= S_IDLE;
			pc     <= RESET_PC;
			credit <= 1'b1;
		end else begin
			// Spent on request, returned by response
			credit <= (credit && !req_valid) || rsp_valid;
			case (state)
				S_IDLE: if (start) state <= S_FETCH;
				S_FETCH: if (req_valid) state <= S_FETCH_WAIT;
				S_FETCH_WAIT: if (rsp_valid) state <= S_EXEC;
				S_EXEC: begin
					if (ctrl.halt) begin
						state <= S_HALT;
					end else if (ctrl.mem_read || ctrl.mem_write) begin
						// PC holds until the data transaction completes
						if (req_valid) state <= S_DATA_WAIT;
					end else begin
						pc    <= pc_next;
						state <= S_FETCH;
					end
				end
				S_DATA_WAIT: begin
					// Store done on its ack
					if (rsp_valid) begin
						pc    <= pc_plus4;
						state <= S_FETCH;
					end
				end
				S_HALT: state <= S_HALT;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (state == S_FETCH_WAIT && rsp_valid) ir <= rsp.rdata;
	end

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter #(
	parameter int MEM_WORDS = 1024
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             host_req_valid,
	input  rv_pkg::mem_req_t host_req,
	output logic             host_rsp_valid,
	output rv_pkg::mem_rsp_t host_rsp,
	input  logic             core_req_valid,
	input  rv_pkg::mem_req_t core_req,
	output logic             core_rsp_valid,
	output rv_pkg::mem_rsp_t core_rsp,
	output logic             mem_req_valid,
	output rv_pkg::mem_req_t mem_req,
	input  logic             mem_rsp_valid,
	input  rv_pkg::mem_rsp_t mem_rsp
);

	logic             host_full;
	logic             core_full;
	rv_pkg::mem_req_t host_buf;
	rv_pkg::mem_req_t core_buf;
	rv_pkg::mem_req_t sel_req;
	logic             grant_host;
	// Source of the request now in memory
	logic             owner_host;

	// Fixed priority, host first
	assign grant_host    = host_full;
	assign mem_req_valid = host_full || core_full;
	assign sel_req       = grant_host ? host_buf : core_buf;

	// Fold address into memory depth
	always_comb begin
		mem_req      = sel_req;
		mem_req.addr = sel_req.addr % MEM_WORDS;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			host_full  <= 1'b0;
			core_full  <= 1'b0;
			owner_host <= 1'b0;
		end else begin
			// Credit guarantees buffer is empty on arrival
			if (host_req_valid) host_full <= 1'b1;
			else if (grant_host) host_full <= 1'b0;
			if (core_req_valid) core_full <= 1'b1;
			else if (core_full && !grant_host) core_full <= 1'b0;
			if (mem_req_valid) owner_host <= grant_host;
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (host_req_valid) host_buf <= host_req;
		if (core_req_valid) core_buf <= core_req;
	end

	// Response steered by owner, data shared
	assign host_rsp_valid = mem_rsp_valid && owner_host;
	assign core_rsp_valid = mem_rsp_valid && !owner_host;
	assign host_rsp       = mem_rsp;
	assign core_rsp       = mem_rsp;

endmodule

//--- src/unified_mem.sv
`timescale 1ns/10ps

module unified_mem #(
	parameter int MEM_WORDS = 1024
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             req_valid,
	input  rv_pkg::mem_req_t req,
	output logic             rsp_valid,
	output rv_pkg::mem_rsp_t rsp
);

	localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] idx;

	// Address already below MEM_WORDS
	assign idx = req.addr[AW-1:0];

	always_ff @(posedge clk) begin
		if (rst) rsp_valid <= 1'b0;
		else rsp_valid <= req_valid;
	end

	// Read first, so a write returns the old word
	always_ff @(posedge clk) begin
		if (req_valid) begin
			rsp.rdata <= mem[idx];
			if (req.we) mem[idx] <= req.wdata;
		end
	end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top #(
	parameter int          MEM_WORDS = 1024,
	parameter logic [31:0] RESET_PC  = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	output logic             halted,
	input  logic             host_req_valid,
	input  rv_pkg::mem_req_t host_req,
	output logic             host_rsp_valid,
	output rv_pkg::mem_rsp_t host_rsp
);

	// Core side of the arbiter
	logic             core_req_valid;
	rv_pkg::mem_req_t core_req;
	logic             core_rsp_valid;
	rv_pkg::mem_rsp_t core_rsp;
	// Memory side of the arbiter
	logic             mem_req_valid;
	rv_pkg::mem_req_t mem_req;
	logic             mem_rsp_valid;
	rv_pkg::mem_rsp_t mem_rsp;

	core_datapath #(.RESET_PC(RESET_PC)) core_datapath_inst (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.halted    (halted),
		.req_valid (core_req_valid),
		.req       (core_req),
		.rsp_valid (core_rsp_valid),
		.rsp       (core_rsp)
	);

	mem_arbiter #(.MEM_WORDS(MEM_WORDS)) mem_arbiter_inst (
		.clk            (clk),
		.rst            (rst),
		.host_req_valid (host_req_valid),
		.host_req       (host_req),
		.host_rsp_valid (host_rsp_valid),
		.host_rsp       (host_rsp),
		.core_req_valid (core_req_valid),
		.core_req       (core_req),
		.core_rsp_valid (core_rsp_valid),
		.core_rsp       (core_rsp),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_rsp_valid  (mem_rsp_valid),
		.mem_rsp        (mem_rsp)
	);

	unified_mem #(.MEM_WORDS(MEM_WORDS)) unified_mem_inst (
		.clk       (clk),
		.rst       (rst),
		.req_valid (mem_req_valid),
		.req       (mem_req),
		.rsp_valid (mem_rsp_valid),
		.rsp       (mem_rsp)
	);

endmodule

//--- test/mem_arbiter_properties.sv
`timescale 1ns/10ps

module mem_arbiter_properties (
	input logic clk,
	input logic rst,
	input logic host_req_valid,
	input logic core_req_valid,
	input logic host_rsp_valid,
	input logic core_rsp_valid,
	input logic mem_req_valid,
	input logic host_full,
	input logic core_full
);

	// Requester awaiting its response
	logic       host_pending;
	logic       core_pending;
	// Requests taken in and not yet sent to memory
	logic [1:0] queued;

	always_ff @(posedge clk) begin
		if (rst) begin
			host_pending <= 1'b0;
			core_pending <= 1'b0;
			queued       <= 2'd0;
		end else begin
			if (host_req_valid) host_pending <= 1'b1;
			else if (host_rsp_valid) host_pending <= 1'b0;
			if (core_req_valid) core_pending <= 1'b1;
			else if (core_rsp_valid) core_pending <= 1'b0;
			queued <= queued + {1'b0, host_req_valid} + {1'b0, core_req_valid}
			          - {1'b0, mem_req_valid};
		end
	end

	// Memory response steered to a waiting requester only
	host_rsp_owner: assert property (@(posedge clk) disable iff (rst)
		host_rsp_valid |-> host_pending)
		else $error("Host response raised with no host request outstanding");

	core_rsp_owner: assert property (@(posedge clk) disable iff (rst)
		core_rsp_valid |-> core_pending)
		else $error("Core response raised with no core request outstanding");

	// Credit keeps the buffers from overflowing
	host_buf_free: assert property (@(posedge clk) disable iff (rst)
		host_req_valid |-> !host_full)
		else $error("Host request arrived into a full buffer");

	core_buf_free: assert property (@(posedge clk) disable iff (rst)
		core_req_valid |-> !core_full)
		else $error("Core request arrived into a full buffer");

	// Nothing forwarded without a buffered request
	mem_req_from_buf: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |-> (queued != 2'd0))
		else $error("Memory request raised with no buffered request");

endmodule

bind mem_arbiter mem_arbiter_properties mem_arbiter_properties_inst (.*);

//--- test/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

	localparam int          MEM_WORDS    = 1024;
	localparam logic [31:0] RESET_PC     = 32'h0000_0100;
	localparam int          RSP_TIMEOUT  = 50;
	localparam int          HALT_TIMEOUT = 100000;
	localparam int          MODEL_STEPS  = 100000;
	localparam int          PROG_BASE    = RESET_PC >> 2;

	// RV32I opcodes
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_ITYPE  = 7'h13;
	localparam logic [6:0] OPC_RTYPE  = 7'h33;
	localparam logic [6:0] OPC_FENCE  = 7'h0f;
	localparam logic [6:0] OPC_SYSTEM = 7'h73;
	localparam logic [31:0] ECALL     = 32'h0000_0073;

	logic             clk = 1'b0;
	logic             rst;
	logic             start;
	logic             halted;
	logic             host_req_valid;
	rv_pkg::mem_req_t host_req;
	logic             host_rsp_valid;
	rv_pkg::mem_rsp_t host_rsp;

	int          errors = 0;
	int          checks = 0;
	// Set after a timeout to skip later host traffic
	bit          dead = 1'b0;
	bit          host_credit = 1'b1;
	// Old-value checks only once every word has a known value
	bit          filled = 1'b0;
	logic [31:0] shadow [MEM_WORDS];
	logic [31:0] prog [$];

	always #20 clk = ~clk;

	rv_core_top #(
		.MEM_WORDS (MEM_WORDS),
		.RESET_PC  (RESET_PC)
	) rv_core_top_inst (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.halted         (halted),
		.host_req_valid (host_req_valid),
		.host_req       (host_req),
		.host_rsp_valid (host_rsp_valid),
		.host_rsp       (host_rsp)
	);

	// Instruction formats
	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
			input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_RTYPE};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input int rd, input int f3,
			input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_type(input int base, input int src, input int off);
		return {off[11:5], src[4:0], base[4:0], 3'b010, off[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opc, input int rd, input int imm);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] j_type(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	// Fill value spreads the whole word address
	function automatic logic [31:0] fill_word(input int addr);
		return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
	endfunction

	// RV32I arithmetic with alt selecting SUB or SRA
	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic bit taken(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (dead) return;
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// One transaction on the host port under its single credit
	task automatic host_access(input logic we, input int addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int cycles;
		rdata = 'x;
		if (dead) return;
		if (!host_credit) begin
			$display("Host request attempted without a credit at %0t", $time);
			errors++;
			return;
		end
		host_req_valid = 1'b1;
		host_req.addr  = addr;
		host_req.wdata = wdata;
		host_req.we    = we;
		host_credit    = 1'b0;
		@(posedge clk);
		#2;
		host_req_valid = 1'b0;
		cycles = 0;
		while (!host_rsp_valid && cycles < RSP_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (host_rsp_valid) begin
			rdata       = host_rsp.rdata;
			host_credit = 1'b1;
		end else begin
			$display("Host response did not arrive within %0d cycles at %0t", RSP_TIMEOUT, $time);
			errors++;
			dead = 1'b1;
		end
	endtask

	// A write returns the old word
	task automatic host_write(input int addr, input logic [31:0] data);
		logic [31:0] old;
		host_access(1'b1, addr, data, old);
		if (filled) begin
			check_word($sformatf("host_rsp.rdata (old value, word %0d)", addr), old, shadow[addr]);
		end
		shadow[addr] = data;
	endtask

	task automatic host_read(input int addr, output logic [31:0] data);
		host_access(1'b0, addr, 32'b0, data);
	endtask

	task automatic read_check(input int addr, input string what);
		logic [31:0] data;
		host_read(addr, data);
		check_word($sformatf("host_rsp.rdata (%s, word %0d)", what, addr), data, shadow[addr]);
	endtask

	task automatic compare_region(input int lo, input int n, input string what);
		for (int i = 0; i < n; i++) begin
			read_check(lo + i, what);
		end
	endtask

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			host_write(PROG_BASE + i, prog[i]);
		end
	endtask

	// Instruction-level model run on the shadow memory
	task automatic model_run();
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] nxt;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        wr;
		logic        done;
		int          steps;
		for (int i = 0; i < 32; i++) x[i] = 32'b0;
		pc    = RESET_PC;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_STEPS) begin
			ins   = shadow[(pc >> 2) % MEM_WORDS];
			a     = x[ins[19:15]];
			b     = x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_u = {ins[31:12], 12'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			res   = 32'b0;
			wr    = 1'b0;
			nxt   = pc + 32'd4;
			case (ins[6:0])
				OPC_LUI: begin
					res = imm_u;
					wr  = 1'b1;
				end
				OPC_AUIPC: begin
					res = pc + imm_u;
					wr  = 1'b1;
				end
				OPC_JAL: begin
					res = pc + 32'd4;
					wr  = 1'b1;
					nxt = pc + imm_j;
				end
				OPC_JALR: begin
					res = pc + 32'd4;
					wr  = 1'b1;
					nxt = (a + imm_i) & ~32'd1;
				end
				OPC_BRANCH: begin
					if (taken(ins[14:12], a, b)) nxt = pc + imm_b;
				end
				OPC_LOAD: begin
					res = shadow[((a + imm_i) >> 2) % MEM_WORDS];
					wr  = 1'b1;
				end
				OPC_STORE: shadow[((a + imm_s) >> 2) % MEM_WORDS] = b;
				OPC_ITYPE: begin
					// Bit 30 means SRAI only
					res = arith(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
					wr  = 1'b1;
				end
				OPC_RTYPE: begin
					res = arith(ins[14:12], ins[30], a, b);
					wr  = 1'b1;
				end
				OPC_SYSTEM: done = (ins[14:12] == 3'd0);
				// FENCE and unknown opcodes do nothing
				default: ;
			endcase
			if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
			pc = nxt;
			steps++;
		end
		if (!done) begin
			$display("Reference model reached no ECALL within %0d steps", MODEL_STEPS);
			errors++;
		end
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (!halted && !dead && cycles < HALT_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halted && !dead) begin
			$display("Core did not halt within %0d cycles", HALT_TIMEOUT);
			errors++;
			dead = 1'b1;
		end
	endtask

	// Fresh core state and one start pulse
	task automatic start_core();
		reset_dut();
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic run_program();
		load_program();
		model_run();
		start_core();
		wait_halt();
	endtask

	task automatic reset_test();
		check_word("halted", halted, 32'd0);
		check_word("host_rsp_valid", host_rsp_valid, 32'd0);
		// ECALL at the reset PC would halt a core that ran without start
		host_write(PROG_BASE, ECALL);
		reset_dut();
		check_word("halted", halted, 32'd0);
		repeat (20) begin
			@(posedge clk);
			#2;
			check_word("halted", halted, 32'd0);
		end
	endtask

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			host_write(i, fill_word(i));
		end
		filled = 1'b1;
	endtask

	task automatic mem_round_trip();
		int addr;
		int addrs [$];
		for (int i = 0; i < 16; i++) begin
			addr = 512 + ($urandom % 512);
			host_write(addr, $urandom);
			read_check(addr, "round trip");
		end
		// Burst of writes and then reads
		for (int i = 0; i < 16; i++) begin
			addr = 512 + ($urandom % 512);
			addrs.push_back(addr);
			host_write(addr, $urandom);
		end
		foreach (addrs[i]) read_check(addrs[i], "burst read");
	endtask

	task automatic arith_test();
		int imm_a;
		int imm_b;
		int sh;
		imm_a = $urandom % 4096;
		imm_b = $urandom % 4096;
		sh    = $urandom % 32;
		prog.delete();
		emit(i_type(OPC_ITYPE, 31, 0, 0, 'h400));
		emit(i_type(OPC_ITYPE, 1, 0, 0, imm_a));
		emit(u_type(OPC_LUI, 3, $urandom));
		emit(i_type(OPC_ITYPE, 3, 0, 3, imm_b));
		emit(u_type(OPC_AUIPC, 4, $urandom));
		emit(r_type(0, 3, 1, 0, 5));
		emit(r_type(32, 3, 1, 0, 6));
		emit(r_type(0, 1, 3, 1, 7));
		emit(r_type(0, 1, 3, 5, 8));
		emit(r_type(32, 1, 3, 5, 9));
		emit(i_type(OPC_ITYPE, 10, 1, 3, sh));
		emit(i_type(OPC_ITYPE, 11, 5, 3, sh));
		emit(i_type(OPC_ITYPE, 12, 5, 3, 'h400 | sh));
		emit(r_type(0, 3, 1, 2, 13));
		emit(r_type(0, 3, 1, 3, 14));
		emit(r_type(0, 3, 1, 4, 15));
		emit(r_type(0, 3, 1, 6, 16));
		emit(r_type(0, 3, 1, 7, 17));
		emit(i_type(OPC_ITYPE, 18, 2, 3, imm_a));
		emit(i_type(OPC_ITYPE, 19, 3, 3, imm_a));
		emit(i_type(OPC_ITYPE, 20, 4, 3, imm_b));
		emit(i_type(OPC_ITYPE, 21, 6, 3, imm_b));
		emit(i_type(OPC_ITYPE, 22, 7, 3, imm_a));
		// x1..x22 to words 256 onward
		for (int r = 1; r <= 22; r++) emit(s_type(31, r, 4 * (r - 1)));
		emit(ECALL);
		run_program();
		compare_region(256, 22, "arith result");
	endtask

	task automatic control_flow_test();
		int          n;
		int          jal_idx;
		int          auipc_idx;
		logic [31:0] data;
		n = 5 + $urandom % 16;
		prog.delete();
		emit(i_type(OPC_ITYPE, 31, 0, 0, 'h400));
		emit(i_type(OPC_ITYPE, 1, 0, 0, 0));
		emit(i_type(OPC_ITYPE, 2, 0, 0, n));
		// Sum n down to 1
		emit(r_type(0, 2, 1, 0, 1));
		emit(i_type(OPC_ITYPE, 2, 0, 2, -1));
		emit(b_type(1, 2, 0, -8));
		// Signed count from -5 up to 3
		emit(i_type(OPC_ITYPE, 3, 0, 0, -5));
		emit(i_type(OPC_ITYPE, 4, 0, 0, 3));
		emit(i_type(OPC_ITYPE, 5, 0, 0, 0));
		emit(i_type(OPC_ITYPE, 5, 0, 5, 1));
		emit(i_type(OPC_ITYPE, 3, 0, 3, 1));
		emit(b_type(4, 3, 4, -8));
		// Unsigned shift-down loop
		emit(i_type(OPC_ITYPE, 6, 0, 0, -1));
		emit(i_type(OPC_ITYPE, 7, 0, 0, 10));
		emit(i_type(OPC_ITYPE, 8, 0, 0, 0));
		emit(i_type(OPC_ITYPE, 8, 0, 8, 1));
		emit(i_type(OPC_ITYPE, 6, 5, 6, 1));
		emit(b_type(7, 6, 7, -8));
		emit(i_type(OPC_FENCE, 0, 0, 0, 'h0ff));
		jal_idx = prog.size();
		emit(j_type(9, 8));
		emit(i_type(OPC_ITYPE, 1, 0, 0, 0));
		auipc_idx = prog.size();
		emit(u_type(OPC_AUIPC, 10, 0));
		emit(i_type(OPC_JALR, 11, 0, 10, 12));
		emit(i_type(OPC_ITYPE, 5, 0, 0, 0));
		emit(s_type(31, 1, 0));
		emit(s_type(31, 5, 4));
		emit(s_type(31, 8, 8));
		emit(s_type(31, 9, 12));
		emit(s_type(31, 10, 16));
		emit(s_type(31, 11, 20));
		emit(ECALL);
		run_program();
		compare_region(256, 6, "control flow result");
		// Direct values from the loop bounds and RESET_PC
		host_read(256, data);
		check_word("loop sum", data, n * (n + 1) / 2);
		host_read(257, data);
		check_word("blt count", data, 32'd8);
		host_read(259, data);
		check_word("jal link", data, RESET_PC + 4 * jal_idx + 4);
		host_read(261, data);
		check_word("jalr link", data, RESET_PC + 4 * auipc_idx + 8);
	endtask

	task automatic load_store_test();
		logic [31:0] sum;
		logic [31:0] data;
		sum = 32'b0;
		// Source words 320..335
		for (int i = 0; i < 16; i++) begin
			data = $urandom;
			sum  = sum + data;
			host_write(320 + i, data);
		end
		prog.delete();
		emit(i_type(OPC_ITYPE, 1, 0, 0, 'h500));
		emit(i_type(OPC_ITYPE, 2, 0, 0, 'h600));
		emit(i_type(OPC_ITYPE, 3, 0, 0, 16));
		emit(i_type(OPC_ITYPE, 4, 0, 0, 0));
		emit(i_type(OPC_LOAD, 5, 2, 1, 0));
		emit(r_type(0, 5, 4, 0, 4));
		emit(s_type(2, 5, 0));
		emit(i_type(OPC_ITYPE, 1, 0, 1, 4));
		emit(i_type(OPC_ITYPE, 2, 0, 2, 4));
		emit(i_type(OPC_ITYPE, 3, 0, 3, -1));
		emit(b_type(1, 3, 0, -24));
		emit(s_type(2, 4, 0));
		emit(ECALL);
		run_program();
		compare_region(320, 16, "load source");
		compare_region(384, 17, "store copy");
		host_read(400, data);
		check_word("load sum", data, sum);
	endtask

	task automatic contention_test();
		int addr;
		// Constant region at words 900..915
		for (int i = 0; i < 16; i++) begin
			host_write(900 + i, fill_word(900 + i) ^ 32'hffff_0000);
		end
		prog.delete();
		emit(i_type(OPC_ITYPE, 31, 0, 0, 'h400));
		emit(u_type(OPC_LUI, 30, 1));
		emit(i_type(OPC_ITYPE, 30, 0, 30, -496));
		emit(i_type(OPC_ITYPE, 1, 0, 0, 0));
		emit(i_type(OPC_ITYPE, 2, 0, 0, 300));
		emit(i_type(OPC_ITYPE, 3, 0, 0, 0));
		emit(i_type(OPC_LOAD, 5, 2, 30, 0));
		emit(r_type(0, 5, 1, 0, 1));
		emit(r_type(0, 2, 1, 0, 1));
		emit(r_type(0, 1, 3, 4, 3));
		emit(i_type(OPC_ITYPE, 2, 0, 2, -1));
		emit(b_type(1, 2, 0, -20));
		emit(s_type(31, 1, 0));
		emit(s_type(31, 3, 4));
		emit(ECALL);
		load_program();
		model_run();
		start_core();
		fork
			wait_halt();
			// Host reads compete with the running core
			while (!halted && !dead) begin
				addr = 900 + $urandom % 16;
				read_check(addr, "contention read");
			end
		join
		compare_region(256, 2, "contention result");
	endtask

	initial begin
		rst            = 1'b1;
		start          = 1'b0;
		host_req_valid = 1'b0;
		host_req       = '0;
		void'($urandom(32'h5042_0a16));
		reset_dut();
		reset_test();
		fill_memory();
		mem_round_trip();
		arith_test();
		control_flow_test();
		load_store_test();
		contention_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- build.f
src/rv_pkg.sv
src/control_unit.sv
src/alu.sv
src/reg_file.sv
src/core_datapath.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_core_top.sv
test/mem_arbiter_properties.sv
test/tb_rv_core.sv
